// File: logic/erx_clk_pkg.sv
package erx_clk_pkg;

   //##################################################
   //# bring-up state
   //##################################################

   // sequencer states, held in one 2-bit word
   typedef enum logic [1:0]
   {
      RESET_ALL = 2'b00,    // pll + calibrator + core all held
      START_PLL = 2'b01,    // pll released, waiting for lock and ready
      ACTIVE    = 2'b10     // core out of reset
   } erx_reset_state_t;

   //##################################################
   //# widths and defaults
   //##################################################

   // behavioral lock / calibration counters
   localparam int ERX_CNT_W = 16;

   // heartbeat counter width, short for simulation
   localparam int ERX_DEF_RCW = 4;

   localparam int ERX_DEF_LOCK_CYCLES = 20;   // rx_clkin edges to lock
   localparam int ERX_DEF_CAL_CYCLES  = 12;   // rx_clkin edges to ready
   localparam int ERX_DEF_SYNC_STAGES = 2;    // reset synchronizer depth

endpackage

// File: logic/erx_reset_sync.sv
`timescale 1ns/1ps

module erx_reset_sync
   import erx_clk_pkg::*;
#(
   parameter int SYNC_STAGES = ERX_DEF_SYNC_STAGES   // chain depth
)
(
   input  logic clk,       // target clock domain
   input  logic arst,      // async reset request
   output logic rst_out    // reset, released on clk
);

   logic [SYNC_STAGES-1:0] sync_q;   // active-low chain

   // async assert, sync release
   always_ff @(posedge clk or posedge arst)
   begin
      if (arst)
         sync_q <= '0;
      else
         sync_q <= (sync_q << 1) | SYNC_STAGES'(1);   // shift ones in
   end

   // release after SYNC_STAGES edges
   assign rst_out = ~sync_q[SYNC_STAGES-1];

endmodule

// File: logic/erx_delay_cal.sv
`timescale 1ns/1ps

module erx_delay_cal
   import erx_clk_pkg::*;
#(
   parameter int CAL_CYCLES = ERX_DEF_CAL_CYCLES   // ref edges to calibrate
)
(
   input  logic rx_clkin,    // reference clock for the tap calibration
   input  logic cal_reset,   // hold from the sequencer
   output logic cal_ready
);

   logic [ERX_CNT_W-1:0] cal_cnt;
   logic [ERX_CNT_W-1:0] cal_cnt_nxt;

   assign cal_cnt_nxt = cal_cnt + 1'b1;

   //##################################################
   //# calibration timer
   //##################################################

   // behavioral model of the delay control block
   // ready is sticky until the next reset
   always_ff @(posedge rx_clkin or posedge cal_reset)
   begin
      if (cal_reset)
      begin
         cal_cnt   <= '0;
         cal_ready <= 1'b0;        // clears at once
      end
      else if (!cal_ready)
      begin
         cal_cnt <= cal_cnt_nxt;
         if (cal_cnt_nxt >= ERX_CNT_W'(CAL_CYCLES))
            cal_ready <= 1'b1;     // set on edge CAL_CYCLES
      end
   end

endmodule

// File: logic/erx_clk_gen.sv
`timescale 1ns/1ps

module erx_clk_gen
   import erx_clk_pkg::*;
#(
   parameter int LOCK_CYCLES = ERX_DEF_LOCK_CYCLES   // ref edges until lock
)
(
   input  logic rx_clkin,       // reference clock
   input  logic pll_reset,      // hold from the sequencer
   output logic rx_lclk,        // fast clock
   output logic rx_lclk_div4,   // slow logic clock, fast / 4
   output logic pll_locked
);

   logic [1:0]           div_cnt;    // fast clock divider
   logic [ERX_CNT_W-1:0] lock_cnt;   // ref edges since release
   logic                 lock_done;

   //##################################################
   //# fast clock
   //##################################################

   // stands in for pll output + global buffer
   // clock stays low while the pll is held
   assign rx_lclk = rx_clkin & ~pll_reset;

   //##################################################
   //# divide by four
   //##################################################

   always_ff @(posedge rx_lclk or posedge pll_reset)
   begin
      if (pll_reset)
         div_cnt <= 2'b00;              // slow clock starts low
      else
         div_cnt <= div_cnt + 1'b1;
   end

   // msb flips every second fast edge
   assign rx_lclk_div4 = div_cnt[1];

   //##################################################
   //# lock counter
   //##################################################

   assign lock_done = (lock_cnt >= ERX_CNT_W'(LOCK_CYCLES));

   // counts on the reference, not on the gated clock
   always_ff @(posedge rx_clkin or posedge pll_reset)
   begin
      if (pll_reset)
         lock_cnt <= '0;
      else if (!lock_done)
         lock_cnt <= lock_cnt + 1'b1;   // saturates at the lock count
   end

   // combinational off the counter, so it drops with pll_reset
   assign pll_locked = lock_done;

endmodule

// File: logic/erx_reset_seq.sv
`timescale 1ns/1ps

module erx_reset_seq
   import erx_clk_pkg::*;
#(
   parameter int RCW = ERX_DEF_RCW           // heartbeat counter width
)
(
   input  logic             sys_clk,         // always-on clock
   input  logic             rx_reset,        // por reset
   input  logic             tx_active,       // tx link alive
   input  logic             soft_reset,      // sw hold
   input  logic             pll_locked,      // from clock source, async
   input  logic             cal_ready,       // from delay calibrator, async
   output logic             pll_reset,
   output logic             cal_reset,
   output logic             core_hold,       // async hold for the core resets
   output erx_reset_state_t rx_state
);

   logic [RCW-1:0]   hb_cnt;          // free-running
   logic             heartbeat;       // one sys_clk pulse per wrap
   logic             locked_meta;
   logic             locked_sync;
   logic             ready_meta;
   logic             ready_sync;
   logic             seq_arst;        // sequencer async reset
   erx_reset_state_t state_q;

   //##################################################
   //# heartbeat
   //##################################################

   // counter wraps every 2**RCW cycles
   always_ff @(posedge sys_clk or posedge rx_reset)
   begin
      if (rx_reset)
      begin
         hb_cnt    <= '0;
         heartbeat <= 1'b0;
      end
      else
      begin
         hb_cnt    <= hb_cnt + 1'b1;
         heartbeat <= (hb_cnt == '0);   // pulse once per wrap
      end
   end

   //##################################################
   //# lock / ready synchronizers
   //##################################################

   always_ff @(posedge sys_clk or posedge rx_reset)
   begin
      if (rx_reset)
      begin
         locked_meta <= 1'b0;
         locked_sync <= 1'b0;
         ready_meta  <= 1'b0;
         ready_sync  <= 1'b0;
      end
      else
      begin
         locked_meta <= pll_locked;     // first stage may go metastable
         locked_sync <= locked_meta;
         ready_meta  <= cal_ready;
         ready_sync  <= ready_meta;
      end
   end

   //##################################################
   //# bring-up fsm
   //##################################################

   // held in reset while por is up or the transmitter is quiet
   assign seq_arst = rx_reset | ~tx_active;

   always_ff @(posedge sys_clk or posedge seq_arst)
   begin
      if (seq_arst)
         state_q <= RESET_ALL;
      else if (heartbeat)              // moves only on a heartbeat
      begin
         case (state_q)
            RESET_ALL :
               if (!soft_reset)
                  state_q <= START_PLL;
            START_PLL :
               if (locked_sync && ready_sync)
                  state_q <= ACTIVE;
            ACTIVE :
               if (soft_reset)
                  state_q <= RESET_ALL;   // back to the start
            default :
               state_q <= RESET_ALL;
         endcase
      end
   end

   assign pll_reset = (state_q == RESET_ALL);
   assign cal_reset = (state_q == RESET_ALL);   // calibrator follows the pll
   assign core_hold = (state_q != ACTIVE);      // core stays held until active
   assign rx_state  = state_q;

endmodule

// File: logic/erx_clocks.sv
`timescale 1ns/1ps

module erx_clocks
   import erx_clk_pkg::*;
#(
   parameter int RCW         = ERX_DEF_RCW,          // heartbeat width
   parameter int LOCK_CYCLES = ERX_DEF_LOCK_CYCLES,
   parameter int CAL_CYCLES  = ERX_DEF_CAL_CYCLES,
   parameter int SYNC_STAGES = ERX_DEF_SYNC_STAGES
)
(
   input  logic             sys_clk,        // always-on clock
   input  logic             rx_reset,       // por reset
   input  logic             soft_reset,     // sw hold
   input  logic             tx_active,      // transmitter alive
   input  logic             rx_clkin,       // receive reference
   output logic             rx_lclk,        // fast io clock
   output logic             rx_lclk_div4,   // slow logic clock
   output logic             erx_reset,      // core reset, slow domain
   output logic             erx_io_reset,   // io reset, fast domain
   output erx_reset_state_t rx_state        // debug status
);

   logic pll_reset;
   logic cal_reset;
   logic core_hold;
   logic pll_locked;
   logic cal_ready;

   //##################################################
   //# sequencer
   //##################################################

   erx_reset_seq #(
      .RCW         (RCW)
   ) u_reset_seq (
      .sys_clk     (sys_clk),
      .rx_reset    (rx_reset),
      .tx_active   (tx_active),
      .soft_reset  (soft_reset),
      .pll_locked  (pll_locked),
      .cal_ready   (cal_ready),
      .pll_reset   (pll_reset),
      .cal_reset   (cal_reset),
      .core_hold   (core_hold),
      .rx_state    (rx_state)
   );

   //##################################################
   //# clock source and delay calibrator
   //##################################################

   erx_clk_gen #(
      .LOCK_CYCLES  (LOCK_CYCLES)
   ) u_clk_gen (
      .rx_clkin     (rx_clkin),
      .pll_reset    (pll_reset),
      .rx_lclk      (rx_lclk),
      .rx_lclk_div4 (rx_lclk_div4),
      .pll_locked   (pll_locked)
   );

   erx_delay_cal #(
      .CAL_CYCLES (CAL_CYCLES)
   ) u_delay_cal (
      .rx_clkin   (rx_clkin),
      .cal_reset  (cal_reset),
      .cal_ready  (cal_ready)
   );

   //##################################################
   //# reset synchronizers
   //##################################################

   // fast domain, for the io
   erx_reset_sync #(
      .SYNC_STAGES (SYNC_STAGES)
   ) u_io_sync (
      .clk         (rx_lclk),
      .arst        (core_hold),
      .rst_out     (erx_io_reset)
   );

   // slow domain, for the core logic
   erx_reset_sync #(
      .SYNC_STAGES (SYNC_STAGES)
   ) u_core_sync (
      .clk         (rx_lclk_div4),
      .arst        (core_hold),
      .rst_out     (erx_reset)
   );

endmodule

// File: tb/tb_erx_clocks.sv
`timescale 1ns/1ps

module tb_erx_clocks
   import erx_clk_pkg::*;
();

   localparam int RCW         = 4;
   localparam int LOCK_CYCLES = 20;
   localparam int CAL_CYCLES  = 12;
   localparam int SYNC_STAGES = 2;
   localparam int SYS_NS      = 100;   // sys_clk period
   localparam int REF_NS      = 25;    // rx_clkin period
   localparam int RST_CYCLES  = 5;
   localparam int MAX_VEC     = 64;
   localparam int FIELDS      = 6;     // words per vector line
   localparam int HB_CYCLES   = 2**RCW;
   // latency bound in sys_clk cycles from soft_reset low to erx_reset low
   localparam int LATENCY_MAX = 3*HB_CYCLES + (LOCK_CYCLES*REF_NS + SYS_NS - 1)/SYS_NS + 2
                                + (SYNC_STAGES*4*REF_NS + SYS_NS - 1)/SYS_NS;

   logic             sys_clk;
   logic             rx_clkin;
   logic             rx_reset;
   logic             soft_reset;
   logic             tx_active;
   logic             rx_lclk;
   logic             rx_lclk_div4;
   logic             erx_reset;
   logic             erx_io_reset;
   erx_reset_state_t rx_state;

   logic [15:0]      vec_mem [0:MAX_VEC*FIELDS-1];
   int               vec_count;
   int               cur_vec;
   int               num_checks;
   int               value_errors;
   int               other_errors;
   int               wd_limit_ns;
   int unsigned      rng_state = 92988;
   erx_reset_state_t prev_exp_state = RESET_ALL;   // expected state of the last vector
   logic             div_prev = 1'b0;
   int               div_edges = 0;
   logic             div_ref = 1'b0;                // a div4 edge seen in ACTIVE

   erx_clocks #(
      .RCW          (RCW),
      .LOCK_CYCLES  (LOCK_CYCLES),
      .CAL_CYCLES   (CAL_CYCLES),
      .SYNC_STAGES  (SYNC_STAGES)
   ) i_erx_clocks (
      .sys_clk      (sys_clk),
      .rx_reset     (rx_reset),
      .soft_reset   (soft_reset),
      .tx_active    (tx_active),
      .rx_clkin     (rx_clkin),
      .rx_lclk      (rx_lclk),
      .rx_lclk_div4 (rx_lclk_div4),
      .erx_reset    (erx_reset),
      .erx_io_reset (erx_io_reset),
      .rx_state     (rx_state)
   );

   //##################################################
   //# clocks
   //##################################################

   always
   begin
      #(SYS_NS/2);
      sys_clk = ~sys_clk;
   end

   // 25 ns ref offset so its edges never meet a sys_clk edge
   always
   begin
      #7.5  rx_clkin = 1'b1;
      #12.5 rx_clkin = 1'b0;
      #5;
   end

   //##################################################
   //# helpers
   //##################################################

   // lcg giving 0..7 idle cycles
   function automatic int unsigned next_idle_cycles();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return (rng_state >> 16) & 32'd7;
   endfunction

   task automatic check_state(input string name, input erx_reset_state_t exp_val,
                              input erx_reset_state_t act_val);
      num_checks++;
      if (act_val !== exp_val)
      begin
         value_errors++;
         $display("FAILED %s expected 0x%h actual 0x%h (vector %0d, %0t)",
                  name, exp_val, act_val, cur_vec, $time);
      end
   endtask

   task automatic check_level(input string name, input logic exp_val, input logic act_val);
      num_checks++;
      if (act_val !== exp_val)
      begin
         value_errors++;
         $display("FAILED %s expected 0x%h actual 0x%h (vector %0d, %0t)",
                  name, exp_val, act_val, cur_vec, $time);
      end
   endtask

   // one file line is driven, held and then checked at the end
   task automatic run_vector(input int idx);
      int               base;
      int               hold;
      int               c;
      int               up_cycle;
      int               down_cycle;
      logic             soft_v;
      logic             tx_v;
      logic             prev_tx;
      erx_reset_state_t exp_state;
      bit               track_up;
      bit               track_down;
      bit               drop_chk;
      base      = idx*FIELDS;
      soft_v    = vec_mem[base][0];
      tx_v      = vec_mem[base+1][0];
      hold      = int'(vec_mem[base+2]);
      exp_state = erx_reset_state_t'(vec_mem[base+3][1:0]);
      cur_vec   = idx;
      repeat (int'(next_idle_cycles())) @(posedge sys_clk);   // inputs unchanged
      prev_tx    = tx_active;
      track_up   = (exp_state == ACTIVE) && (prev_exp_state != ACTIVE);
      track_down = (exp_state == RESET_ALL) && (prev_exp_state == ACTIVE) && soft_v && tx_v;
      drop_chk   = prev_tx && !tx_v;
      up_cycle   = 0;
      down_cycle = 0;
      @(posedge sys_clk);
      soft_reset <= soft_v;
      tx_active  <= tx_v;
      for (c = 1; c <= hold; c++)
      begin
         @(negedge sys_clk);        // mid-cycle where outputs are settled
         if (drop_chk && c == 1)    // tx drop acts without a clock
         begin
            check_state("rx_state", RESET_ALL, rx_state);
            check_level("erx_reset", 1'b1, erx_reset);
            check_level("erx_io_reset", 1'b1, erx_io_reset);
         end
         if (track_up && up_cycle == 0 && !erx_reset && !erx_io_reset)
            up_cycle = c;
         if (track_down && down_cycle == 0 && rx_state == RESET_ALL)
            down_cycle = c;
      end
      if (track_up && (up_cycle == 0 || up_cycle > LATENCY_MAX))
      begin
         other_errors++;
         $display("vector %0d: core resets did not both fall within %0d cycles", idx, LATENCY_MAX);
      end
      if (track_down && (down_cycle == 0 || down_cycle > HB_CYCLES + 1))
      begin
         other_errors++;
         $display("vector %0d: soft reset took longer than one heartbeat period", idx);
      end
      check_state("rx_state", exp_state, rx_state);
      check_level("erx_reset", vec_mem[base+4][0], erx_reset);
      check_level("erx_io_reset", vec_mem[base+5][0], erx_io_reset);
      if (exp_state == RESET_ALL)
      begin
         @(posedge rx_clkin);       // sample while the reference is high
         #1;
         check_level("rx_lclk", 1'b0, rx_lclk);   // clock gated while pll held
      end
      prev_exp_state = exp_state;
   endtask

   //##################################################
   //# divide-by-four monitor
   //##################################################

   // sees the level from before this edge so changes come 2 edges apart
   always @(posedge rx_lclk)
   begin
      if (rx_state != ACTIVE)
      begin
         div_ref   = 1'b0;
         div_edges = 0;
      end
      else
      begin
         div_edges++;
         if (rx_lclk_div4 !== div_prev)
         begin
            if (div_ref && div_edges != 2)
            begin
               other_errors++;
               $display("rx_lclk_div4 changed after %0d rx_lclk edges instead of 2 at %0t",
                        div_edges, $time);
            end
            div_ref   = 1'b1;
            div_edges = 0;
         end
      end
      div_prev = rx_lclk_div4;
   end

   //##################################################
   //# main sequence and watchdog
   //##################################################

   initial
   begin
      int i;
      int sum_holds;
      sys_clk      = 1'b0;
      rx_clkin     = 1'b0;
      rx_reset     = 1'b1;
      soft_reset   = 1'b1;      // software holds the link at power-up
      tx_active    = 1'b1;
      num_checks   = 0;
      value_errors = 0;
      other_errors = 0;
      cur_vec      = 0;
      for (i = 0; i < MAX_VEC*FIELDS; i++)
         vec_mem[i] = '0;       // zero hold ends the list
      $readmemh("tb/erx_clocks_input.txt", vec_mem);
      vec_count = 0;
      sum_holds = 0;
      while (vec_count < MAX_VEC && vec_mem[vec_count*FIELDS+2] != 16'h0)
      begin
         sum_holds += int'(vec_mem[vec_count*FIELDS+2]);
         vec_count++;
      end
      wd_limit_ns = (2*(sum_holds + 8*vec_count) + RST_CYCLES) * SYS_NS;
      if (vec_count == 0)
      begin
         other_errors++;
         $display("no vectors were read from tb/erx_clocks_input.txt");
      end
      repeat (RST_CYCLES) @(posedge sys_clk);
      rx_reset <= 1'b0;
      for (i = 0; i < vec_count; i++)
         run_vector(i);
      $display("checks %0d, value errors %0d, other errors %0d",
               num_checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

   initial
   begin
      #1;                       // limit is set at time 0
      #(wd_limit_ns);
      other_errors++;
      $display("timeout: run did not finish within %0d ns", wd_limit_ns);
      $display("checks %0d, value errors %0d, other errors %0d",
               num_checks, value_errors, other_errors);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: tb/erx_clocks_input.txt
// soft_reset tx_active hold_cycles exp_rx_state exp_erx_reset exp_erx_io_reset
// all hex; rx_state 0 = RESET_ALL, 1 = START_PLL, 2 = ACTIVE
// power-up, software still holding
1 1 50 0 1 1
// release, bring-up to ACTIVE
0 1 50 2 0 0
// stay active, div4 monitor running
0 1 50 2 0 0
// software hold back on
1 1 50 0 1 1
// release again
0 1 50 2 0 0
// transmitter goes quiet while active
0 0 50 0 1 1
// transmitter back, bring-up again
0 1 50 2 0 0
// software hold from ACTIVE
1 1 50 0 1 1
// quiet link while already held
1 0 50 0 1 1
// both released together
0 1 60 2 0 0
// second drop from ACTIVE
0 0 50 0 1 1
// final bring-up
0 1 50 2 0 0

// File: files.f
logic/erx_clk_pkg.sv
logic/erx_reset_sync.sv
logic/erx_delay_cal.sv
logic/erx_clk_gen.sv
logic/erx_reset_seq.sv
logic/erx_clocks.sv
tb/tb_erx_clocks.sv

// File: run_sim.sh
#!/bin/sh
# build and run the erx_clocks testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --top-module tb_erx_clocks \
   -f files.f \
   -o sim_erx_clocks

./obj_dir/sim_erx_clocks > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log
then
   echo "simulation failed"
   exit 1
fi

if ! grep -q "TEST RESULT: PASS" sim.log
then
   echo "simulation ended without a result"
   exit 1
fi

echo "simulation passed"
